//--- issue_core.f
hdl/isa_pkg.sv
hdl/issue_pkg.sv
hdl/reg_file.sv
hdl/issue_read_operands.sv
hdl/exec_lane.sv
hdl/writeback_arbiter.sv
hdl/issue_core.sv
tb/tb_issue_core.sv

//--- run_sim.sh
#!/bin/sh
# build the issue core testbench with verilator, run it, then scan the log

rm -f sim.log &&
verilator --binary --timing --assert -j 0 --top-module tb_issue_core \
    -f issue_core.f --Mdir obj_dir &&
./obj_dir/Vtb_issue_core > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; } ||
echo "simulation finished without failure"

//--- tb/tb_issue_core.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// issue core testbench
// directed and lfsr tests against an in-order reference model
// ----------------------------------------------------------------------
module tb_issue_core;

    localparam int NUM_LANES   = 3;
    // 11 + 9 + 5 + 3 + 200 instructions over all tests
    localparam int TOTAL_INSTR = 228;
    localparam int MAX_CYCLES  = TOTAL_INSTR * 12 + 200;

    logic                           clk_i;
    logic                           rst_ni;
    isa_pkg::instr_u                instr_i;
    logic                           instr_valid_i;
    logic                           instr_ready_o;
    logic [isa_pkg::REG_ADDR_W-1:0] dbg_addr_i;
    logic [isa_pkg::XLEN-1:0]       dbg_data_o;
    issue_pkg::wb_t                 wb_o;

    // in-order shadow state and expected writebacks in program order
    logic [31:0] shadow [32];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          cycles;
    string       test_name;

    issue_core #(
        .NUM_LANES ( NUM_LANES )
    ) uut (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .instr_i       ( instr_i       ),
        .instr_valid_i ( instr_valid_i ),
        .instr_ready_o ( instr_ready_o ),
        .dbg_addr_i    ( dbg_addr_i    ),
        .dbg_data_o    ( dbg_data_o    ),
        .wb_o          ( wb_o          )
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] encode_r(isa_pkg::op_e op, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
        return {op, 1'b0, rd, rs1, rs2, 12'h000};
    endfunction

    function automatic logic [31:0] encode_i(isa_pkg::op_e op, logic [4:0] rd,
                                             logic [4:0] rs1, logic [16:0] imm);
        return {op, 1'b1, rd, rs1, imm};
    endfunction

    // galois lfsr, taps 16 14 13 11, one step per bit
    function automatic logic lfsr_bit();
        logic lsb;
        lsb    = lfsr_q[0];
        lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lsb ? 16'hb400 : 16'h0000);
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
        end
    endtask

    // reference model, executes one word in program order
    task automatic model_execute(input logic [31:0] word);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        rd = word[26:22];
        a  = shadow[word[21:17]];
        // i form takes a signed 17-bit immediate
        b  = word[27] ? {{15{word[16]}}, word[16:0]} : shadow[word[16:12]];
        case (word[31:28])
            isa_pkg::ADD: res = a + b;
            isa_pkg::SUB: res = a - b;
            isa_pkg::AND: res = a & b;
            isa_pkg::OR:  res = a | b;
            isa_pkg::XOR: res = a ^ b;
            isa_pkg::SLL: res = a << b[4:0];
            isa_pkg::SRL: res = a >> b[4:0];
            isa_pkg::MUL: res = a * b;
            default:      res = '0;
        endcase
        // x0 keeps zero and never shows on the write port
        if (rd != 5'd0) begin
            shadow[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endtask

    // drive on the falling edge, hold valid until ready was seen high
    task automatic send_instr(input logic [31:0] word);
        @(negedge clk_i);
        instr_i       = word;
        instr_valid_i = 1'b1;
        #1;
        while (!instr_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        // handshake at the coming rising edge
        model_execute(word);
    endtask

    task automatic wait_drained();
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        while (exp_rd_q.size() != 0) begin
            @(negedge clk_i);
        end
        // let x0 results leave the lanes too
        repeat (4) @(negedge clk_i);
    endtask

    task automatic compare_regfile(input string name);
        for (int r = 0; r < 32; r++) begin
            @(negedge clk_i);
            dbg_addr_i = r[4:0];
            #1;
            check_value($sformatf("%s x%0d", name, r), shadow[r], dbg_data_o);
        end
    endtask

    // ------------------------------------------------------------------
    // writeback monitor
    // ------------------------------------------------------------------
    // wb_o only depends on lane state, so it is steady at the falling edge
    always @(negedge clk_i) begin
        int idx;
        idx = -1;
        if (rst_ni && wb_o.we) begin
            // same-rd writes are serialized, so the oldest entry for rd matches
            for (int i = 0; i < exp_rd_q.size(); i++) begin
                if (idx < 0 && exp_rd_q[i] == wb_o.rd) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                errors++;
                $display("%s: writeback to x%0d that no instruction asked for",
                         test_name, wb_o.rd);
            end else begin
                check_value($sformatf("%s wb x%0d", test_name, wb_o.rd),
                            exp_data_q[idx], wb_o.data);
                exp_rd_q.delete(idx);
                exp_data_q.delete(idx);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("timeout after %0d cycles, the core stopped making progress", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    task automatic test_reset();
        test_name = "reset";
        @(negedge clk_i);
        #1;
        check_value("reset wb_o.we", 32'd0, {31'd0, wb_o.we});
        compare_regfile("reset");
    endtask

    task automatic test_ops();
        test_name = "ops";
        send_instr(encode_i(isa_pkg::ADD, 5'd1, 5'd0, 17'd100));
        // -7 in 17 bits
        send_instr(encode_i(isa_pkg::ADD, 5'd2, 5'd0, 17'h1fff9));
        send_instr(encode_i(isa_pkg::ADD, 5'd3, 5'd0, 17'h0ffff));
        send_instr(encode_r(isa_pkg::SUB, 5'd4, 5'd1, 5'd2));
        send_instr(encode_r(isa_pkg::AND, 5'd5, 5'd1, 5'd3));
        send_instr(encode_r(isa_pkg::OR, 5'd6, 5'd2, 5'd1));
        send_instr(encode_r(isa_pkg::XOR, 5'd7, 5'd3, 5'd2));
        send_instr(encode_i(isa_pkg::SLL, 5'd8, 5'd1, 17'd4));
        send_instr(encode_i(isa_pkg::SRL, 5'd9, 5'd2, 17'd28));
        // shift amount from x1, low 5 bits of 100
        send_instr(encode_r(isa_pkg::SLL, 5'd10, 5'd3, 5'd1));
        send_instr(encode_r(isa_pkg::MUL, 5'd11, 5'd2, 5'd1));
        wait_drained();
        compare_regfile("ops final");
    endtask

    task automatic test_raw_chain();
        test_name = "raw chain";
        send_instr(encode_i(isa_pkg::ADD, 5'd1, 5'd0, 17'd3));
        send_instr(encode_i(isa_pkg::ADD, 5'd2, 5'd1, 17'd1));
        send_instr(encode_r(isa_pkg::MUL, 5'd3, 5'd2, 5'd2));
        send_instr(encode_r(isa_pkg::SUB, 5'd4, 5'd3, 5'd1));
        send_instr(encode_i(isa_pkg::SLL, 5'd5, 5'd4, 17'd2));
        send_instr(encode_r(isa_pkg::XOR, 5'd6, 5'd5, 5'd4));
        send_instr(encode_i(isa_pkg::SRL, 5'd7, 5'd6, 17'd1));
        // waw on x1 as well as raw
        send_instr(encode_r(isa_pkg::ADD, 5'd1, 5'd7, 5'd1));
        send_instr(encode_r(isa_pkg::MUL, 5'd2, 5'd1, 5'd1));
        wait_drained();
        compare_regfile("raw chain final");
    endtask

    task automatic test_mul_overtake();
        test_name = "mul overtake";
        // slow mul in lane 0, adds can retire before it
        send_instr(encode_r(isa_pkg::MUL, 5'd10, 5'd1, 5'd2));
        send_instr(encode_i(isa_pkg::ADD, 5'd11, 5'd0, 17'd5));
        send_instr(encode_i(isa_pkg::ADD, 5'd12, 5'd0, 17'd6));
        send_instr(encode_i(isa_pkg::ADD, 5'd13, 5'd0, 17'd7));
        send_instr(encode_r(isa_pkg::MUL, 5'd14, 5'd10, 5'd11));
        wait_drained();
        compare_regfile("mul overtake final");
    endtask

    task automatic test_x0_writes();
        test_name = "x0 writes";
        send_instr(encode_i(isa_pkg::ADD, 5'd0, 5'd0, 17'd55));
        send_instr(encode_r(isa_pkg::XOR, 5'd0, 5'd1, 5'd2));
        send_instr(encode_i(isa_pkg::ADD, 5'd15, 5'd0, 17'd1));
        wait_drained();
        compare_regfile("x0 writes final");
    endtask

    task automatic test_random();
        logic [31:0]  r;
        logic [31:0]  imm;
        isa_pkg::op_e op;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            // half of the ops are mul to keep lanes occupied
            r = rand_bits(1);
            if (r[0]) begin
                op = isa_pkg::MUL;
            end else begin
                r  = rand_bits(3);
                op = isa_pkg::op_e'({1'b0, r[2:0]});
            end
            r   = rand_bits(2);
            rd  = r[4:0] + 5'd1;
            r   = rand_bits(2);
            rs1 = r[4:0] + 5'd1;
            r   = rand_bits(2);
            rs2 = r[4:0];
            r   = rand_bits(1);
            if (r[0]) begin
                imm = rand_bits(17);
                send_instr(encode_i(op, rd, rs1, imm[16:0]));
            end else begin
                send_instr(encode_r(op, rd, rs1, rs2));
            end
        end
        wait_drained();
        compare_regfile("random final");
    endtask

    initial begin
        errors        = 0;
        checks        = 0;
        cycles        = 0;
        lfsr_q        = 16'd66;
        test_name     = "init";
        instr_i       = '0;
        instr_valid_i = 1'b0;
        dbg_addr_i    = '0;
        rst_ni        = 1'b0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (16) @(negedge clk_i);
        rst_ni = 1'b1;

        test_reset();
        test_ops();
        test_raw_chain();
        test_mul_overtake();
        test_x0_writes();
        test_random();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/issue_core.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// issue core top
// issue stage, a row of execution lanes and the writeback arbiter
// ----------------------------------------------------------------------
module issue_core #(
    parameter int unsigned NUM_LANES = 3
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  isa_pkg::instr_u                instr_i,
    input  logic                           instr_valid_i,
    output logic                           instr_ready_o,
    input  logic [isa_pkg::REG_ADDR_W-1:0] dbg_addr_i,
    output logic [isa_pkg::XLEN-1:0]       dbg_data_o,
    output issue_pkg::wb_t                 wb_o
);
    issue_pkg::lane_req_t                 lane_req;
    logic [NUM_LANES-1:0]                 lane_valid;
    logic [NUM_LANES-1:0]                 lane_ready;
    issue_pkg::lane_res_t [NUM_LANES-1:0] res;
    logic [NUM_LANES-1:0]                 res_valid;
    logic [NUM_LANES-1:0]                 res_ready;

    // the write port feeds the outside and the issue stage alike
    issue_read_operands #(
        .NUM_LANES ( NUM_LANES )
    ) u_issue (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .instr_i       ( instr_i       ),
        .instr_valid_i ( instr_valid_i ),
        .instr_ready_o ( instr_ready_o ),
        .wb_i          ( wb_o          ),
        .lane_req_o    ( lane_req      ),
        .lane_valid_o  ( lane_valid    ),
        .lane_ready_i  ( lane_ready    ),
        .dbg_addr_i    ( dbg_addr_i    ),
        .dbg_data_o    ( dbg_data_o    )
    );

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        exec_lane u_lane (
            .clk_i       ( clk_i         ),
            .rst_ni      ( rst_ni        ),
            .req_i       ( lane_req      ),
            .req_valid_i ( lane_valid[k] ),
            .req_ready_o ( lane_ready[k] ),
            .res_o       ( res[k]        ),
            .res_valid_o ( res_valid[k]  ),
            .res_ready_i ( res_ready[k]  )
        );
    end

    writeback_arbiter #(
        .NUM_LANES ( NUM_LANES )
    ) u_arbiter (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .res_i       ( res       ),
        .res_valid_i ( res_valid ),
        .res_ready_o ( res_ready ),
        .wb_o        ( wb_o      )
    );

endmodule

//--- hdl/writeback_arbiter.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// writeback arbiter
// fixed priority over lane results, lowest index wins the write port
// ----------------------------------------------------------------------
module writeback_arbiter #(
    parameter int unsigned NUM_LANES = 3
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    input  issue_pkg::lane_res_t [NUM_LANES-1:0] res_i,
    input  logic [NUM_LANES-1:0]                 res_valid_i,
    output logic [NUM_LANES-1:0]                 res_ready_o,
    output issue_pkg::wb_t                       wb_o
);
    logic granted;

    always_comb begin
        res_ready_o = '0;
        wb_o        = '0;
        granted     = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (res_valid_i[k] && !granted) begin
                res_ready_o[k] = 1'b1;
                granted        = 1'b1;
                wb_o.rd        = res_i[k].rd;
                wb_o.data      = res_i[k].data;
                // x0 results still retire, but never write
                wb_o.we        = (res_i[k].rd != '0);
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(res_ready_o))
        else $error("writeback_arbiter: grant not one-hot");

endmodule

//--- hdl/exec_lane.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// execution lane
// single-cycle logic and arithmetic, three-cycle multiply
// ----------------------------------------------------------------------
module exec_lane (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  issue_pkg::lane_req_t req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output issue_pkg::lane_res_t res_o,
    output logic                 res_valid_o,
    input  logic                 res_ready_i
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_COMPUTE,
        S_DONE
    } state_e;

    // extra compute cycles for mul after the first one
    localparam logic [1:0] MUL_WAIT = 2'd2;

    state_e                   state_q;
    logic [1:0]               cnt_q;
    issue_pkg::lane_req_t     req_q;
    logic [isa_pkg::XLEN-1:0] result;

    assign req_ready_o = (state_q == S_IDLE);
    assign res_valid_o = (state_q == S_DONE);

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_valid_i) begin
                        // non-mul ops are ready right after the dispatch edge
                        if (req_i.op == isa_pkg::MUL) begin
                            state_q <= S_COMPUTE;
                            cnt_q   <= MUL_WAIT;
                        end else begin
                            state_q <= S_DONE;
                        end
                    end
                end
                S_COMPUTE: begin
                    if (cnt_q == '0) begin
                        state_q <= S_DONE;
                    end else begin
                        cnt_q <= cnt_q - 2'd1;
                    end
                end
                S_DONE: begin
                    // hold until the arbiter grants us
                    if (res_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // input register, payload only
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
    end

    // ------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------
    always_comb begin
        case (req_q.op)
            isa_pkg::ADD: result = req_q.operand_a + req_q.operand_b;
            isa_pkg::SUB: result = req_q.operand_a - req_q.operand_b;
            isa_pkg::AND: result = req_q.operand_a & req_q.operand_b;
            isa_pkg::OR:  result = req_q.operand_a | req_q.operand_b;
            isa_pkg::XOR: result = req_q.operand_a ^ req_q.operand_b;
            // shift amount is the low 5 bits of b
            isa_pkg::SLL: result = req_q.operand_a << req_q.operand_b[4:0];
            isa_pkg::SRL: result = req_q.operand_a >> req_q.operand_b[4:0];
            // low half of the product
            isa_pkg::MUL: result = req_q.operand_a * req_q.operand_b;
            default:      result = '0;
        endcase
    end

    assign res_o.rd   = req_q.rd;
    assign res_o.data = result;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
        else $error("exec_lane: result changed before grant");

endmodule

//--- hdl/issue_read_operands.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// issue stage
// decode, clobber table, hazard stall, operand read and forwarding,
// dispatch to the lowest free lane
// ----------------------------------------------------------------------
module issue_read_operands #(
    parameter int unsigned NUM_LANES = 3
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    // instruction stream
    input  isa_pkg::instr_u                instr_i,
    input  logic                           instr_valid_i,
    output logic                           instr_ready_o,
    // writeback from the arbiter
    input  issue_pkg::wb_t                 wb_i,
    // lanes, payload is shared and valid is one-hot
    output issue_pkg::lane_req_t           lane_req_o,
    output logic [NUM_LANES-1:0]           lane_valid_o,
    input  logic [NUM_LANES-1:0]           lane_ready_i,
    // debug read
    input  logic [isa_pkg::REG_ADDR_W-1:0] dbg_addr_i,
    output logic [isa_pkg::XLEN-1:0]       dbg_data_o
);
    logic [isa_pkg::REG_ADDR_W-1:0] rd;
    logic [isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [isa_pkg::REG_ADDR_W-1:0] rs2;
    logic                           use_imm;
    logic [isa_pkg::XLEN-1:0]       imm_ext;
    logic [isa_pkg::XLEN-1:0]       rf_a;
    logic [isa_pkg::XLEN-1:0]       rf_b;
    logic [isa_pkg::NUM_REGS-1:0]   clobber_q;
    logic                           pend_rs1;
    logic                           pend_rs2;
    logic                           pend_rd;
    logic                           fwd_rs1;
    logic                           fwd_rs2;
    logic                           hazard;
    logic [NUM_LANES-1:0]           lane_sel;
    logic                           lane_found;
    logic                           issue;

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    // op, rd and rs1 sit at the same place in both views
    assign use_imm = instr_i.r_form.use_imm;
    assign rd      = instr_i.r_form.rd;
    assign rs1     = instr_i.r_form.rs1;
    assign rs2     = instr_i.r_form.rs2;
    assign imm_ext = {{(isa_pkg::XLEN - isa_pkg::IMM_W){instr_i.i_form.imm[isa_pkg::IMM_W-1]}},
                      instr_i.i_form.imm};

    // ------------------------------------------------------------------
    // hazard check
    // ------------------------------------------------------------------
    // a register written back this cycle is no longer pending
    assign pend_rs1 = clobber_q[rs1] && !(wb_i.we && wb_i.rd == rs1);
    assign pend_rs2 = clobber_q[rs2] && !(wb_i.we && wb_i.rd == rs2);
    assign pend_rd  = clobber_q[rd] && !(wb_i.we && wb_i.rd == rd);
    // rs2 only matters in r form, rd covers waw
    assign hazard   = pend_rs1 || (!use_imm && pend_rs2) || pend_rd;

    // lowest index free lane wins
    always_comb begin
        lane_sel   = '0;
        lane_found = 1'b0;
        for (int k = 0; k < NUM_LANES; k++) begin
            if (lane_ready_i[k] && !lane_found) begin
                lane_sel[k] = 1'b1;
                lane_found  = 1'b1;
            end
        end
    end

    assign instr_ready_o = lane_found && !hazard;
    assign issue         = instr_valid_i && instr_ready_o;
    assign lane_valid_o  = {NUM_LANES{issue}} & lane_sel;

    // ------------------------------------------------------------------
    // operands and forwarding
    // ------------------------------------------------------------------
    assign fwd_rs1 = wb_i.we && wb_i.rd == rs1 && rs1 != '0;
    assign fwd_rs2 = wb_i.we && wb_i.rd == rs2 && rs2 != '0;

    always_comb begin
        lane_req_o.op        = instr_i.r_form.op;
        lane_req_o.rd        = rd;
        lane_req_o.operand_a = fwd_rs1 ? wb_i.data : rf_a;
        if (use_imm) begin
            lane_req_o.operand_b = imm_ext;
        end else begin
            lane_req_o.operand_b = fwd_rs2 ? wb_i.data : rf_b;
        end
    end

    // set on issue, clear on writeback
    // set wins when the same rd retires and issues in one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            clobber_q <= '0;
        end else begin
            if (wb_i.we) begin
                clobber_q[wb_i.rd] <= 1'b0;
            end
            if (issue && rd != '0) begin
                clobber_q[rd] <= 1'b1;
            end
        end
    end

    reg_file u_reg_file (
        .clk_i       ( clk_i      ),
        .rst_ni      ( rst_ni     ),
        .raddr_a_i   ( rs1        ),
        .raddr_b_i   ( rs2        ),
        .raddr_dbg_i ( dbg_addr_i ),
        .wb_i        ( wb_i       ),
        .rdata_a_o   ( rf_a       ),
        .rdata_b_o   ( rf_b       ),
        .rdata_dbg_o ( dbg_data_o )
    );

    assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(lane_valid_o))
        else $error("issue: dispatch to more than one lane");

    // the lane ready comes from the lane state, not from this stage
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lane_valid_o & ~lane_ready_i) == '0)
        else $error("issue: dispatch to a busy lane");

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// register file
// flop array, x0 reads zero, two operand reads, debug read, one write
// ----------------------------------------------------------------------
module reg_file (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
    input  logic [isa_pkg::REG_ADDR_W-1:0] raddr_dbg_i,
    input  issue_pkg::wb_t                 wb_i,
    output logic [isa_pkg::XLEN-1:0]       rdata_a_o,
    output logic [isa_pkg::XLEN-1:0]       rdata_b_o,
    output logic [isa_pkg::XLEN-1:0]       rdata_dbg_o
);
    logic [isa_pkg::XLEN-1:0] regs_q [isa_pkg::NUM_REGS];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 0; r < isa_pkg::NUM_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (wb_i.we && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // plain reads, the issue stage forwards same-cycle writes itself
    assign rdata_a_o   = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o   = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];
    assign rdata_dbg_o = (raddr_dbg_i == '0) ? '0 : regs_q[raddr_dbg_i];

    // x0 results are dropped by the arbiter and never set pending,
    // so an enabled write to x0 here means the upstream logic is broken
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_i.we |-> wb_i.rd != '0)
        else $error("reg_file: write enable with rd 0");

endmodule

//--- hdl/issue_pkg.sv
// ----------------------------------------------------------------------
// issue core payloads
// structs passed between issue stage, lanes and writeback arbiter
// ----------------------------------------------------------------------
package issue_pkg;

    // dispatch payload, shared by all lanes
    typedef struct packed {
        isa_pkg::op_e                   op;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]       operand_a;
        logic [isa_pkg::XLEN-1:0]       operand_b;
    } lane_req_t;

    // lane result waiting for its writeback slot
    typedef struct packed {
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]       data;
    } lane_res_t;

    // register file write port
    // also clears the clobber bit and feeds forwarding
    typedef struct packed {
        logic                           we;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]       data;
    } wb_t;

endpackage

//--- hdl/isa_pkg.sv
// ----------------------------------------------------------------------
// toy isa definitions
// instruction word layout, operation codes and basic widths
// ----------------------------------------------------------------------
package isa_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned NUM_REGS   = 1 << REG_ADDR_W;
    // i form immediate, sign extended to XLEN at issue
    localparam int unsigned IMM_W      = 17;

    typedef enum logic [3:0] {
        ADD = 4'h0,
        SUB = 4'h1,
        AND = 4'h2,
        OR  = 4'h3,
        XOR = 4'h4,
        SLL = 4'h5,
        SRL = 4'h6,
        MUL = 4'h7
    } op_e;

    // r form, both operands from the register file
    typedef struct packed {
        op_e                   op;
        logic                  use_imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [11:0]           unused;
    } r_form_t;

    // i form, rs2 and the pad bits become a signed immediate
    typedef struct packed {
        op_e                     op;
        logic                    use_imm;
        logic [REG_ADDR_W-1:0]   rd;
        logic [REG_ADDR_W-1:0]   rs1;
        logic signed [IMM_W-1:0] imm;
    } i_form_t;

    // one instruction word, use_imm picks the view
    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_u;

endpackage
